//--- rtl/cacheGeomPkg.sv
package cacheGeomPkg;

  // address and data widths
  localparam int AddrWidth = 32;
  localparam int XLen = 64;

  // four words per line, 32 bytes
  localparam int LineWords = 4;
  localparam int OffsetWidth = 5;
  localparam int IndexWidth = 6;
  localparam int TagWidth = 21;

  // array geometry
  localparam int NumSets = 64;
  localparam int NumWays = 2;
  localparam int LineWidth = 256;

  typedef logic [AddrWidth-1:0] addrT;
  // address bits 31 to 11
  typedef logic [TagWidth-1:0] tagT;
  // address bits 10 to 5
  typedef logic [IndexWidth-1:0] indexT;
  typedef logic [XLen-1:0] wordT;
  // word 0 sits in the low bits
  typedef logic [LineWidth-1:0] lineT;
  typedef logic [$clog2(NumWays)-1:0] wayT;

endpackage

//--- rtl/cacheCtrlPkg.sv
package cacheCtrlPkg;

  // lookup controller
  typedef enum logic [2:0] {
    Idle,
    Compare,
    Miss,
    Refill,
    Replay
  } ctrlStateT;

  // refill sequencer
  typedef enum logic [1:0] {
    RfIdle,
    RfBurst,
    RfWrite
  } refillStateT;

endpackage

//--- rtl/lineWriteIf.sv
`timescale 1ns/1ps

interface lineWriteIf;

  // one-cycle strobe for a whole line fill
  logic wen;
  cacheGeomPkg::indexT index;
  cacheGeomPkg::wayT way;
  cacheGeomPkg::tagT tag;
  cacheGeomPkg::lineT line;

  modport refillSide (
    output wen, index, way, tag, line
  );

  modport arraySide (
    input wen, index, way, tag, line
  );

endinterface

//--- rtl/dataWaySram.sv
`timescale 1ns/1ps

module dataWaySram #(
  parameter int WayIdx = 0
) (
  input  logic                 clk,
  input  logic                 rdEn_i,
  input  cacheGeomPkg::indexT  rdIndex_i,
  lineWriteIf.arraySide        fill,
  output cacheGeomPkg::lineT   rdLine_o
);

  cacheGeomPkg::lineT mem [cacheGeomPkg::NumSets];

  logic wrHere;

  // only fills aimed at this way land here
  assign wrHere = fill.wen && (fill.way == cacheGeomPkg::wayT'(WayIdx));

  always_ff @(posedge clk) begin
    if (wrHere) begin
      mem[fill.index] <= fill.line;
    end
  end

  // registered read, data valid the cycle after rdEn_i
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      rdLine_o <= mem[rdIndex_i];
    end
  end

endmodule

//--- rtl/tagValidArray.sv
`timescale 1ns/1ps

module tagValidArray (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rdEn_i,
  input  cacheGeomPkg::indexT  rdIndex_i,
  input  cacheGeomPkg::tagT    cmpTag_i,
  input  logic                 cmpEn_i,
  lineWriteIf.arraySide        fill,
  output logic                 hit_o,
  output cacheGeomPkg::wayT    hitWay_o,
  output cacheGeomPkg::wayT    victimWay_o
);

  cacheGeomPkg::tagT tagMem [cacheGeomPkg::NumWays][cacheGeomPkg::NumSets];
  logic [cacheGeomPkg::NumWays-1:0][cacheGeomPkg::NumSets-1:0] validQ;
  // per set, the way to replace next
  logic [cacheGeomPkg::NumSets-1:0] lruQ;

  cacheGeomPkg::tagT rdTag [cacheGeomPkg::NumWays];
  logic [cacheGeomPkg::NumWays-1:0] rdValid;
  cacheGeomPkg::indexT rdIndexQ;
  logic [cacheGeomPkg::NumWays-1:0] wayHit;

  always_ff @(posedge clk) begin
    if (fill.wen) begin
      tagMem[fill.way][fill.index] <= fill.tag;
    end
    if (rdEn_i) begin
      for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
        rdTag[w] <= tagMem[w][rdIndex_i];
      end
      rdIndexQ <= rdIndex_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      lruQ <= '0;
      rdValid <= '0;
    end else begin
      if (rdEn_i) begin
        for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
          rdValid[w] <= validQ[w][rdIndex_i];
        end
      end
      // a hit makes the other way the older one
      if (hit_o) begin
        lruQ[rdIndexQ] <= ~hitWay_o;
      end
      if (fill.wen) begin
        validQ[fill.way][fill.index] <= 1'b1;
        lruQ[fill.index] <= ~fill.way;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
      wayHit[w] = rdValid[w] && (rdTag[w] == cmpTag_i);
    end
  end

  assign hit_o = cmpEn_i && (|wayHit);
  assign hitWay_o = wayHit[1] ? 1'b1 : 1'b0;

  // empty way first, otherwise the least recently used one
  always_comb begin
    if (!rdValid[0]) begin
      victimWay_o = 1'b0;
    end else if (!rdValid[1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lruQ[rdIndexQ];
    end
  end

endmodule

//--- rtl/refillUnit.sv
`timescale 1ns/1ps

module refillUnit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  cacheGeomPkg::addrT   lineAddr_i,
  input  cacheGeomPkg::wayT    way_i,
  input  cacheGeomPkg::wordT   memRdData_i,
  input  logic                 memRdBeat_i,
  input  logic                 memRdLast_i,
  output logic                 memRdValid_o,
  output cacheGeomPkg::addrT   memAddr_o,
  output logic                 done_o,
  lineWriteIf.refillSide       fill
);

  cacheCtrlPkg::refillStateT state, nextState;

  cacheGeomPkg::addrT lineAddrQ;
  cacheGeomPkg::wayT wayQ;
  cacheGeomPkg::lineT lineBuf;
  logic [$clog2(cacheGeomPkg::LineWords)-1:0] beatCnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cacheCtrlPkg::RfIdle;
      beatCnt <= '0;
    end else begin
      state <= nextState;
      if (state == cacheCtrlPkg::RfIdle) begin
        beatCnt <= '0;
      end else if (memRdBeat_i && (state == cacheCtrlPkg::RfBurst)) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // request and line buffer
  always_ff @(posedge clk) begin
    if (start_i && (state == cacheCtrlPkg::RfIdle)) begin
      lineAddrQ <= lineAddr_i;
      wayQ <= way_i;
    end
    if (memRdBeat_i && (state == cacheCtrlPkg::RfBurst)) begin
      lineBuf[beatCnt*cacheGeomPkg::XLen +: cacheGeomPkg::XLen] <= memRdData_i;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cacheCtrlPkg::RfIdle: begin
        if (start_i) begin
          nextState = cacheCtrlPkg::RfBurst;
        end
      end
      cacheCtrlPkg::RfBurst: begin
        if (memRdBeat_i && memRdLast_i) begin
          nextState = cacheCtrlPkg::RfWrite;
        end
      end
      default: begin
        nextState = cacheCtrlPkg::RfIdle;
      end
    endcase
  end

  // address held for the whole burst
  assign memRdValid_o = (state == cacheCtrlPkg::RfBurst);
  assign memAddr_o = lineAddrQ;

  // line write and done in the cycle after the last beat
  assign done_o = (state == cacheCtrlPkg::RfWrite);
  assign fill.wen = done_o;
  assign fill.index = lineAddrQ[cacheGeomPkg::OffsetWidth +: cacheGeomPkg::IndexWidth];
  assign fill.tag = lineAddrQ[cacheGeomPkg::AddrWidth-1 -: cacheGeomPkg::TagWidth];
  assign fill.way = wayQ;
  assign fill.line = lineBuf;

endmodule

//--- rtl/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  cacheGeomPkg::addrT   reqAddr_i,
  input  logic                 hit_i,
  input  cacheGeomPkg::wayT    hitWay_i,
  input  cacheGeomPkg::wayT    victimWay_i,
  input  cacheGeomPkg::lineT   way0Line_i,
  input  cacheGeomPkg::lineT   way1Line_i,
  input  logic                 refillDone_i,
  output logic                 addrOk_o,
  output logic                 dataOk_o,
  output cacheGeomPkg::wordT   rdData_o,
  output logic                 rdEn_o,
  output cacheGeomPkg::indexT  rdIndex_o,
  output cacheGeomPkg::tagT    cmpTag_o,
  output logic                 cmpEn_o,
  output logic                 refillStart_o,
  output cacheGeomPkg::addrT   refillLineAddr_o,
  output cacheGeomPkg::wayT    refillWay_o
);

  cacheCtrlPkg::ctrlStateT state, nextState;

  cacheGeomPkg::addrT reqQ;
  logic accept;
  logic [1:0] wordSel;
  cacheGeomPkg::lineT hitLine;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cacheCtrlPkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  // address of the request now in lookup
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= reqAddr_i;
    end
  end

  always_comb begin
    nextState = state;
    addrOk_o = 1'b0;
    dataOk_o = 1'b0;
    accept = 1'b0;
    rdEn_o = 1'b0;
    rdIndex_o = reqAddr_i[cacheGeomPkg::OffsetWidth +: cacheGeomPkg::IndexWidth];
    cmpEn_o = 1'b0;
    refillStart_o = 1'b0;
    case (state)
      cacheCtrlPkg::Idle: begin
        addrOk_o = 1'b1;
        if (reqValid_i) begin
          accept = 1'b1;
          rdEn_o = 1'b1;
          nextState = cacheCtrlPkg::Compare;
        end
      end
      cacheCtrlPkg::Compare: begin
        cmpEn_o = 1'b1;
        if (hit_i) begin
          dataOk_o = 1'b1;
          // next request may overlap a hit
          addrOk_o = 1'b1;
          if (reqValid_i) begin
            accept = 1'b1;
            rdEn_o = 1'b1;
          end else begin
            nextState = cacheCtrlPkg::Idle;
          end
        end else begin
          nextState = cacheCtrlPkg::Miss;
        end
      end
      cacheCtrlPkg::Miss: begin
        refillStart_o = 1'b1;
        nextState = cacheCtrlPkg::Refill;
      end
      cacheCtrlPkg::Refill: begin
        if (refillDone_i) begin
          nextState = cacheCtrlPkg::Replay;
        end
      end
      cacheCtrlPkg::Replay: begin
        // re-read the set for the latched request
        rdEn_o = 1'b1;
        rdIndex_o = reqQ[cacheGeomPkg::OffsetWidth +: cacheGeomPkg::IndexWidth];
        nextState = cacheCtrlPkg::Compare;
      end
      default: begin
        nextState = cacheCtrlPkg::Idle;
      end
    endcase
  end

  assign cmpTag_o = reqQ[cacheGeomPkg::AddrWidth-1 -: cacheGeomPkg::TagWidth];

  // line-aligned fetch address; victim still valid from the last read
  assign refillLineAddr_o = {reqQ[cacheGeomPkg::AddrWidth-1:cacheGeomPkg::OffsetWidth],
                             {cacheGeomPkg::OffsetWidth{1'b0}}};
  assign refillWay_o = victimWay_i;

  // word select, offset bits 4 to 3
  assign wordSel = reqQ[cacheGeomPkg::OffsetWidth-1 -: 2];
  assign hitLine = hitWay_i ? way1Line_i : way0Line_i;
  assign rdData_o = hitLine[wordSel*cacheGeomPkg::XLen +: cacheGeomPkg::XLen];

endmodule

//--- rtl/cacheTop.sv
`timescale 1ns/1ps

module cacheTop (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  cacheGeomPkg::addrT   reqAddr_i,
  input  cacheGeomPkg::wordT   memRdData_i,
  input  logic                 memRdBeat_i,
  input  logic                 memRdLast_i,
  output logic                 addrOk_o,
  output logic                 dataOk_o,
  output cacheGeomPkg::wordT   rdData_o,
  output logic                 memRdValid_o,
  output cacheGeomPkg::addrT   memAddr_o
);

  logic hit;
  cacheGeomPkg::wayT hitWay;
  cacheGeomPkg::wayT victimWay;
  cacheGeomPkg::lineT way0Line;
  cacheGeomPkg::lineT way1Line;
  logic refillDone;
  logic rdEn;
  cacheGeomPkg::indexT rdIndex;
  cacheGeomPkg::tagT cmpTag;
  logic cmpEn;
  logic refillStart;
  cacheGeomPkg::addrT refillLineAddr;
  cacheGeomPkg::wayT refillWay;

  // line fill path from refill unit to all arrays
  lineWriteIf u_fill ();

  cacheCtrl u_cacheCtrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .reqAddr_i        (reqAddr_i),
    .hit_i            (hit),
    .hitWay_i         (hitWay),
    .victimWay_i      (victimWay),
    .way0Line_i       (way0Line),
    .way1Line_i       (way1Line),
    .refillDone_i     (refillDone),
    .addrOk_o         (addrOk_o),
    .dataOk_o         (dataOk_o),
    .rdData_o         (rdData_o),
    .rdEn_o           (rdEn),
    .rdIndex_o        (rdIndex),
    .cmpTag_o         (cmpTag),
    .cmpEn_o          (cmpEn),
    .refillStart_o    (refillStart),
    .refillLineAddr_o (refillLineAddr),
    .refillWay_o      (refillWay)
  );

  tagValidArray u_tagValidArray (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdEn_i      (rdEn),
    .rdIndex_i   (rdIndex),
    .cmpTag_i    (cmpTag),
    .cmpEn_i     (cmpEn),
    .fill        (u_fill),
    .hit_o       (hit),
    .hitWay_o    (hitWay),
    .victimWay_o (victimWay)
  );

  dataWaySram #(.WayIdx(0)) u_dataWay0 (
    .clk       (clk),
    .rdEn_i    (rdEn),
    .rdIndex_i (rdIndex),
    .fill      (u_fill),
    .rdLine_o  (way0Line)
  );

  dataWaySram #(.WayIdx(1)) u_dataWay1 (
    .clk       (clk),
    .rdEn_i    (rdEn),
    .rdIndex_i (rdIndex),
    .fill      (u_fill),
    .rdLine_o  (way1Line)
  );

  refillUnit u_refillUnit (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (refillStart),
    .lineAddr_i   (refillLineAddr),
    .way_i        (refillWay),
    .memRdData_i  (memRdData_i),
    .memRdBeat_i  (memRdBeat_i),
    .memRdLast_i  (memRdLast_i),
    .memRdValid_o (memRdValid_o),
    .memAddr_o    (memAddr_o),
    .done_o       (refillDone),
    .fill         (u_fill)
  );

endmodule

//--- test/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int PeriodNs = 20
) (
  output logic clk_o
);

  // free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

//--- test/cacheMonitor.sv
`timescale 1ns/1ps

module cacheMonitor (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reqValid_i,
  input  cacheGeomPkg::addrT  reqAddr_i,
  input  logic                addrOk_i,
  input  logic                dataOk_i,
  input  cacheGeomPkg::wordT  rdData_i,
  input  logic                memRdValid_i,
  input  cacheGeomPkg::addrT  memAddr_i,
  input  int                  testNum_i,
  input  logic                expHit_i,
  output int                  errCnt_o,
  output int                  doneCnt_o,
  output int                  memReqCnt_o
);

  typedef struct packed {
    int                 test;
    cacheGeomPkg::addrT addr;
    logic               expHit;
    int                 acceptCycle;
  } pendT;

  pendT pending [$];

  // reference copy of tags, valid bits and LRU bits
  cacheGeomPkg::tagT mTag [cacheGeomPkg::NumWays][cacheGeomPkg::NumSets];
  logic mValid [cacheGeomPkg::NumWays][cacheGeomPkg::NumSets];
  logic mLru [cacheGeomPkg::NumSets];

  int cycle;
  int headMemReqs;
  int errCnt;
  int doneCnt;
  int memReqCnt;
  logic memValidQ;

  assign errCnt_o = errCnt;
  assign doneCnt_o = doneCnt;
  assign memReqCnt_o = memReqCnt;

  initial begin
    errCnt = 0;
    doneCnt = 0;
    memReqCnt = 0;
    cycle = 0;
  end

  // upper half of each memory word is the inverted address
  function automatic cacheGeomPkg::wordT memWord(input cacheGeomPkg::addrT a);
    return {~a, a};
  endfunction

  // looks up and updates the model, returns the hit flag
  function automatic logic modelAccess(input cacheGeomPkg::addrT a);
    logic [5:0] idx;
    logic [20:0] tg;
    logic hit;
    int way;
    idx = a[10:5];
    tg = a[31:11];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
      if (mValid[w][idx] && (mTag[w][idx] == tg)) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // empty way first, then the older one
      if (!mValid[0][idx]) begin
        way = 0;
      end else if (!mValid[1][idx]) begin
        way = 1;
      end else begin
        way = int'(mLru[idx]);
      end
      mTag[way][idx] = tg;
      mValid[way][idx] = 1'b1;
    end
    mLru[idx] = (way == 0);
    return hit;
  endfunction

  task automatic clearModel();
    for (int s = 0; s < cacheGeomPkg::NumSets; s++) begin
      mValid[0][s] = 1'b0;
      mValid[1][s] = 1'b0;
      mLru[s] = 1'b0;
    end
  endtask

  task automatic logFailure(input string msg);
    $display("%s", msg);
    errCnt++;
  endtask

  always @(posedge clk or negedge rst_n) begin
    pendT head;
    int lat;
    cacheGeomPkg::wordT expWord;
    int errBefore;
    if (!rst_n) begin
      clearModel();
      pending.delete();
      headMemReqs = 0;
      memValidQ = 1'b0;
    end else begin
      cycle++;
      // start of a new burst on the memory port
      if (memRdValid_i && !memValidQ) begin
        memReqCnt++;
        headMemReqs++;
        if (pending.size() == 0) begin
          logFailure("memory request issued while no lookup was pending");
        end else if (memAddr_i !== {pending[0].addr[31:5], 5'd0}) begin
          logFailure($sformatf("Error: memAddr_o = %h, expected %h", memAddr_i,
                               {pending[0].addr[31:5], 5'd0}));
        end
      end
      memValidQ = memRdValid_i;

      if (dataOk_i) begin
        if (pending.size() == 0) begin
          logFailure("dataOk_o was raised with no request outstanding");
        end else begin
          head = pending.pop_front();
          errBefore = errCnt;
          lat = cycle - head.acceptCycle;
          expWord = memWord({head.addr[31:3], 3'd0});
          if (rdData_i !== expWord) begin
            logFailure($sformatf("Error: rdData_o = %h, expected %h", rdData_i, expWord));
          end
          if (head.expHit && ((lat != 1) || (headMemReqs != 0))) begin
            logFailure($sformatf("hit expected but it took %0d cycles and %0d memory requests",
                                 lat, headMemReqs));
          end
          if (!head.expHit && (headMemReqs != 1)) begin
            logFailure($sformatf("miss expected one memory request, saw %0d", headMemReqs));
          end
          doneCnt++;
          $display("test %0d: addr %h %s, %0d cycles, %s", head.test, head.addr,
                   head.expHit ? "hit" : "miss", lat, (errCnt == errBefore) ? "ok" : "bad");
          headMemReqs = 0;
        end
      end

      if (reqValid_i && addrOk_i) begin
        if (modelAccess(reqAddr_i) != expHit_i) begin
          logFailure($sformatf("LRU model disagrees with the table at addr %h", reqAddr_i));
        end
        pending.push_back('{testNum_i, reqAddr_i, expHit_i, cycle});
      end
    end
  end

endmodule

//--- test/cacheTop_checker.sv
`timescale 1ns/1ps

module cacheTop_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     reqValid_i,
  input logic                     addrOk_i,
  input logic                     dataOk_i,
  input logic                     memRdValid_i,
  input cacheGeomPkg::addrT       memAddr_i,
  input logic                     memRdBeat_i,
  input logic                     memRdLast_i,
  input cacheCtrlPkg::ctrlStateT  ctrlState_i
);

  // accepted requests not yet answered
  logic [2:0] outstanding;
  int failCnt;

  initial failCnt = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 3'd0;
    end else if ((reqValid_i && addrOk_i) && !dataOk_i) begin
      outstanding <= outstanding + 3'd1;
    end else if (!(reqValid_i && addrOk_i) && dataOk_i) begin
      outstanding <= outstanding - 3'd1;
    end
  end

  memAddrAligned: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_i |-> (memAddr_i[cacheGeomPkg::OffsetWidth-1:0] == '0))
  else begin
    $error("memAddr_o is not line aligned");
    failCnt++;
  end

  memAddrStable: assert property (@(posedge clk) disable iff (!rst_n)
    (memRdValid_i && $past(memRdValid_i)) |-> $stable(memAddr_i))
  else begin
    $error("memAddr_o changed during a burst");
    failCnt++;
  end

  validDropAfterLast: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(memRdValid_i) |-> $past(memRdBeat_i && memRdLast_i))
  else begin
    $error("memRdValid_o fell before the last beat");
    failCnt++;
  end

  dataOkHasRequest: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i |-> (outstanding != 3'd0))
  else begin
    $error("dataOk_o with no accepted request");
    failCnt++;
  end

  // no new request while a line is being fetched
  noAcceptInRefill: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrlState_i == cacheCtrlPkg::Refill) |-> !addrOk_i)
  else begin
    $error("addrOk_o high in Refill");
    failCnt++;
  end

endmodule

//--- test/cacheTop_tb.sv
`timescale 1ns/1ps

module cacheTop_tb;

  localparam int NumRows = 22;
  localparam int TimeoutCycles = NumRows * (4 * 4 + 8) + 50;

  typedef struct packed {
    int          test;
    logic [31:0] addr;
    logic        backToBack;
    logic        expHit;
  } rowT;

  rowT rows [NumRows];

  logic clk;
  logic rst_n;
  logic reqValid;
  cacheGeomPkg::addrT reqAddr;
  cacheGeomPkg::wordT memRdData;
  logic memRdBeat;
  logic memRdLast;
  logic addrOk;
  logic dataOk;
  cacheGeomPkg::wordT rdData;
  logic memRdValid;
  cacheGeomPkg::addrT memAddr;
  int testNum;
  logic expHit;
  int monErrors;
  int doneCnt;
  int memReqs;
  int cycleCnt;

  tbClock u_tbClock (
    .clk_o (clk)
  );

  cacheTop u_cacheTop (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid),
    .reqAddr_i    (reqAddr),
    .memRdData_i  (memRdData),
    .memRdBeat_i  (memRdBeat),
    .memRdLast_i  (memRdLast),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .memRdValid_o (memRdValid),
    .memAddr_o    (memAddr)
  );

  cacheMonitor u_cacheMonitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid),
    .reqAddr_i    (reqAddr),
    .addrOk_i     (addrOk),
    .dataOk_i     (dataOk),
    .rdData_i     (rdData),
    .memRdValid_i (memRdValid),
    .memAddr_i    (memAddr),
    .testNum_i    (testNum),
    .expHit_i     (expHit),
    .errCnt_o     (monErrors),
    .doneCnt_o    (doneCnt),
    .memReqCnt_o  (memReqs)
  );

  bind cacheTop cacheTop_checker u_cacheTop_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .addrOk_i     (addrOk_o),
    .dataOk_i     (dataOk_o),
    .memRdValid_i (memRdValid_o),
    .memAddr_i    (memAddr_o),
    .memRdBeat_i  (memRdBeat_i),
    .memRdLast_i  (memRdLast_i),
    .ctrlState_i  (u_cacheCtrl.state)
  );

  function automatic cacheGeomPkg::wordT memWord(input cacheGeomPkg::addrT a);
    return {~a, a};
  endfunction

  // test, address, back-to-back, expected hit; set 3 holds tags A, B, C
  task automatic loadRows();
    rows[0]  = '{1, 32'h0000_0070, 1'b0, 1'b0};
    rows[1]  = '{1, 32'h0000_1008, 1'b0, 1'b0};
    rows[2]  = '{2, 32'h0000_0060, 1'b0, 1'b1};
    rows[3]  = '{2, 32'h0000_0068, 1'b0, 1'b1};
    rows[4]  = '{2, 32'h0000_0078, 1'b0, 1'b1};
    rows[5]  = '{2, 32'h0000_1018, 1'b0, 1'b1};
    rows[6]  = '{3, 32'h0001_0060, 1'b0, 1'b0};
    rows[7]  = '{3, 32'h0000_0068, 1'b0, 1'b1};
    rows[8]  = '{3, 32'h0001_0070, 1'b0, 1'b1};
    rows[9]  = '{3, 32'h0000_0070, 1'b0, 1'b1};
    rows[10] = '{3, 32'h0001_0078, 1'b0, 1'b1};
    // tag C evicts A, B stays, then A comes back over C
    rows[11] = '{4, 32'h0002_0060, 1'b0, 1'b0};
    rows[12] = '{4, 32'h0001_0068, 1'b0, 1'b1};
    rows[13] = '{4, 32'h0000_0060, 1'b0, 1'b0};
    rows[14] = '{4, 32'h0002_0068, 1'b0, 1'b0};
    rows[15] = '{5, 32'h0002_0060, 1'b1, 1'b1};
    rows[16] = '{5, 32'h0000_0078, 1'b1, 1'b1};
    rows[17] = '{5, 32'h0002_0070, 1'b1, 1'b1};
    rows[18] = '{5, 32'h0000_1000, 1'b1, 1'b1};
    rows[19] = '{5, 32'h0000_0060, 1'b0, 1'b1};
    rows[20] = '{6, 32'h0000_0060, 1'b0, 1'b0};
    rows[21] = '{6, 32'h0000_1010, 1'b0, 1'b0};
  endtask

  task automatic applyReset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic sendRow(input int i);
    @(negedge clk);
    reqValid = 1'b1;
    reqAddr = rows[i].addr;
    testNum = rows[i].test;
    expHit = rows[i].expHit;
    // addrOk_o only depends on registered state
    while (!addrOk) @(negedge clk);
    if (!rows[i].backToBack) begin
      @(negedge clk);
      reqValid = 1'b0;
      while (!dataOk) @(negedge clk);
    end
  endtask

  // memory model, four beats with random gaps
  initial begin
    cacheGeomPkg::addrT base;
    int gap;
    void'($urandom(32'hcb01_856c));
    memRdBeat = 1'b0;
    memRdLast = 1'b0;
    memRdData = '0;
    forever begin
      @(negedge clk);
      if (rst_n && memRdValid) begin
        base = memAddr;
        for (int b = 0; b < 4; b++) begin
          gap = $urandom_range(3, 0);
          repeat (gap) @(negedge clk);
          memRdBeat = 1'b1;
          memRdData = memWord(base + 32'(b * 8));
          memRdLast = (b == 3);
          @(negedge clk);
          memRdBeat = 1'b0;
          memRdLast = 1'b0;
        end
      end
    end
  end

  initial begin
    cycleCnt = 0;
    while (cycleCnt < TimeoutCycles) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("run timed out after %0d cycles without finishing the table", cycleCnt);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int chkFails;
    int total;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqAddr = '0;
    testNum = 0;
    expHit = 1'b0;
    loadRows();
    applyReset();
    for (int i = 0; i < NumRows; i++) begin
      // reset once before the first test 6 row
      if ((i > 0) && (rows[i].test == 6) && (rows[i-1].test != 6)) begin
        applyReset();
      end
      sendRow(i);
    end
    repeat (2) @(negedge clk);
    chkFails = u_cacheTop.u_cacheTop_checker.failCnt;
    total = monErrors + chkFails;
    if (doneCnt != NumRows) begin
      $display("only %0d of %0d requests completed", doneCnt, NumRows);
      total++;
    end
    $display("summary: %0d requests, %0d memory requests, %0d errors, %0d assertion failures",
             doneCnt, memReqs, monErrors, chkFails);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- cacheTop.f
rtl/cacheGeomPkg.sv
rtl/cacheCtrlPkg.sv
rtl/lineWriteIf.sv
rtl/dataWaySram.sv
rtl/tagValidArray.sv
rtl/refillUnit.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
test/tbClock.sv
test/cacheMonitor.sv
test/cacheTop_checker.sv
test/cacheTop_tb.sv

//--- Makefile
TOP       ?= cacheTop_tb
FILELIST  ?= cacheTop.f
LOG       ?= sim.log
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
